/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_iagc
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/iagc_pkg.sv */
package iagc_pkg;

  localparam int SAMPLE_W      = 16;
  localparam int MEM_DEPTH     = 256;
  localparam int MEM_AW        = 8;
  localparam int LED_PWM_TICKS = 50;
  localparam int WD_TIMEOUT    = 2000;

  localparam logic [1:0] REG_CMD    = 2'd0;
  localparam logic [1:0] REG_DATA   = 2'd1;
  localparam logic [1:0] REG_STATUS = 2'd2;

  typedef enum logic [3:0] {
    RESET     = 4'd0,
    INIT      = 4'd1,
    IDLE      = 4'd2,
    SAMPLE    = 4'd3,
    CMD_PARSE = 4'd4,
    CMD_READ  = 4'd5,
    CMD_ERROR = 4'd6,
    DUMP_REF  = 4'd7,
    DUMP_ERR  = 4'd8,
    CLEAN_MEM = 4'd9,
    SET_MEM   = 4'd10,
    SET_DEC   = 4'd11,
    HALT      = 4'd12
  } iagc_status_e;

  typedef enum logic [3:0] {
    OP_CLEAN    = 4'd1,
    OP_SET_MEM  = 4'd2,
    OP_SET_DEC  = 4'd3,
    OP_SAMPLE   = 4'd4,
    OP_DUMP_REF = 4'd5,
    OP_DUMP_ERR = 4'd6,
    OP_HALT     = 4'd7
  } iagc_op_e;

  typedef struct packed {
    logic [3:0]          opcode;
    logic [3:0]          pad;
    logic [MEM_AW-1:0]   address;
    logic [SAMPLE_W-1:0] data;
  } mem_cmd_t;

  typedef struct packed {
    logic [3:0]          opcode;
    logic [11:0]         pad;
    logic [SAMPLE_W-1:0] value;
  } cfg_cmd_t;

  // same word, address/data view for SET_MEM, value view otherwise.
  typedef union packed {
    mem_cmd_t mem;
    cfg_cmd_t cfg;
  } iagc_cmd_u;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic r;
    logic g;
    logic b;
  } rgb_t;

  typedef struct packed {
    logic                clear_start;
    logic                set_mem;
    logic                set_dec;
    logic                capture_start;
    logic                dump_start;
    logic                dump_sel;      // 0 selects reference, 1 error.
    logic                dump_next;
    logic [MEM_AW-1:0]   addr;
    logic [SAMPLE_W-1:0] data;
    logic [SAMPLE_W-1:0] value;
  } buf_ctrl_t;

endpackage

/* flist.f */
common/iagc_pkg.sv
hw/wb_cmd_port.sv
hw/iagc_ctrl.sv
hw/sample_buffer.sv
hw/host_watchdog.sv
hw/status_leds.sv
hw/iagc_top.sv
tests/tb_clock_gen.sv
tests/tb_iagc.sv

/* hw/host_watchdog.sv */
`timescale 1ns/1ns

module host_watchdog (
  input  logic i_clock,
  input  logic i_arst_n,
  input  logic i_kick,
  output logic o_wd_valid
);
  import iagc_pkg::*;

  localparam int CNT_W = $clog2(WD_TIMEOUT + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      count <= CNT_W'(WD_TIMEOUT); // valid right out of reset.
    end else if (i_kick) begin
      count <= CNT_W'(WD_TIMEOUT);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign o_wd_valid = (count != '0);

endmodule

/* hw/iagc_ctrl.sv */
`timescale 1ns/1ns

module iagc_ctrl (
  input  logic                   i_clock,
  input  logic                   i_arst_n,
  input  logic                   i_cmd_valid,
  input  iagc_pkg::iagc_cmd_u    i_cmd,
  input  logic                   i_data_rd,
  input  logic                   i_status_rd,
  input  logic                   i_busy_done,
  output iagc_pkg::buf_ctrl_t    o_buf_op,
  output iagc_pkg::iagc_status_e o_status,
  output logic                   o_reject
);
  import iagc_pkg::*;

  iagc_status_e    state;
  iagc_cmd_u       cmd_q;
  iagc_op_e        op;
  buf_ctrl_t       buf_op;
  logic [MEM_AW:0] req_count;
  logic [MEM_AW:0] cap_count;
  logic [MEM_AW:0] dump_cnt;
  logic            reject;

  assign op = iagc_op_e'(cmd_q.mem.opcode);

  // zero or oversized counts capture the whole buffer.
  always_comb begin
    if ((cmd_q.cfg.value == '0) || (cmd_q.cfg.value > MEM_DEPTH)) begin
      req_count = (MEM_AW + 1)'(MEM_DEPTH);
    end else begin
      req_count = cmd_q.cfg.value[MEM_AW:0];
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_cmd_valid && (state == IDLE)) begin
      cmd_q <= i_cmd;
    end
  end

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state     <= RESET;
      buf_op    <= '0;
      cap_count <= (MEM_AW + 1)'(MEM_DEPTH);
      dump_cnt  <= '0;
    end else begin
      buf_op.clear_start   <= 1'b0;
      buf_op.set_mem       <= 1'b0;
      buf_op.set_dec       <= 1'b0;
      buf_op.capture_start <= 1'b0;
      buf_op.dump_start    <= 1'b0;
      buf_op.dump_next     <= 1'b0;
      case (state)
        RESET: begin
          state              <= INIT;
          buf_op.clear_start <= 1'b1; // power-up clear of both memories.
        end
        INIT, CLEAN_MEM, SAMPLE: begin
          if (i_busy_done) begin
            state <= IDLE;
          end
        end
        IDLE: begin
          if (i_cmd_valid) begin
            state <= CMD_PARSE;
          end
        end
        CMD_PARSE: begin
          case (op)
            OP_CLEAN: begin
              state              <= CLEAN_MEM;
              buf_op.clear_start <= 1'b1;
            end
            OP_SET_MEM: begin
              state          <= SET_MEM;
              buf_op.set_mem <= 1'b1;
              buf_op.addr    <= cmd_q.mem.address;
              buf_op.data    <= cmd_q.mem.data;
            end
            OP_SET_DEC: begin
              state          <= SET_DEC;
              buf_op.set_dec <= 1'b1;
              buf_op.value   <= cmd_q.cfg.value;
            end
            OP_SAMPLE: begin
              state                <= SAMPLE;
              buf_op.capture_start <= 1'b1;
              buf_op.value         <= SAMPLE_W'(req_count);
              cap_count            <= req_count;
            end
            OP_DUMP_REF, OP_DUMP_ERR: begin
              state             <= (op == OP_DUMP_REF) ? DUMP_REF : DUMP_ERR;
              buf_op.dump_start <= 1'b1;
              buf_op.dump_sel   <= (op == OP_DUMP_ERR);
              dump_cnt          <= '0;
            end
            OP_HALT: begin
              state <= HALT;
            end
            default: begin
              state <= CMD_ERROR;
            end
          endcase
        end
        SET_MEM, SET_DEC, CMD_ERROR: begin
          state <= IDLE;
        end
        DUMP_REF, DUMP_ERR: begin
          if (i_data_rd) begin
            buf_op.dump_next <= 1'b1;
            if (dump_cnt == cap_count - 1'b1) begin
              state <= IDLE; // last word of the capture handed out.
            end else begin
              dump_cnt <= dump_cnt + 1'b1;
            end
          end
        end
        default: begin
          state <= state; // halt holds until reset.
        end
      endcase
    end
  end

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      reject <= 1'b0;
    end else if ((i_cmd_valid && (state != IDLE)) || (state == CMD_ERROR)) begin
      reject <= 1'b1;
    end else if (i_status_rd) begin
      reject <= 1'b0;
    end
  end

  assign o_buf_op = buf_op;
  assign o_status = state;
  assign o_reject = reject;

endmodule

/* hw/iagc_top.sv */
`timescale 1ns/1ns

module iagc_top (
  input  logic                          i_clock,
  input  logic                          i_arst_n,
  input  iagc_pkg::wb_req_t             i_wb,
  output iagc_pkg::wb_rsp_t             o_wb,
  input  logic [iagc_pkg::SAMPLE_W-1:0] i_sample,
  input  logic                          i_sample_valid,
  output iagc_pkg::rgb_t                o_led0,
  output iagc_pkg::rgb_t                o_led1
);
  import iagc_pkg::*;

  logic                cmd_valid;
  iagc_cmd_u           cmd;
  logic                data_rd;
  logic                status_rd;
  logic                busy_done;
  logic                reject;
  logic                wd_valid;
  logic [SAMPLE_W-1:0] rd_data;
  buf_ctrl_t           buf_op;
  iagc_status_e        status;

  wb_cmd_port u_port (
    .i_clock     (i_clock),
    .i_arst_n    (i_arst_n),
    .i_wb        (i_wb),
    .o_wb        (o_wb),
    .o_cmd_valid (cmd_valid),
    .o_cmd       (cmd),
    .o_data_rd   (data_rd),
    .i_status    (status),
    .i_reject    (reject),
    .o_status_rd (status_rd),
    .i_wd_valid  (wd_valid),
    .i_rd_data   (rd_data)
  );

  iagc_ctrl u_ctrl (
    .i_clock     (i_clock),
    .i_arst_n    (i_arst_n),
    .i_cmd_valid (cmd_valid),
    .i_cmd       (cmd),
    .i_data_rd   (data_rd),
    .i_status_rd (status_rd),
    .i_busy_done (busy_done),
    .o_buf_op    (buf_op),
    .o_status    (status),
    .o_reject    (reject)
  );

  sample_buffer u_buffer (
    .i_clock        (i_clock),
    .i_arst_n       (i_arst_n),
    .i_buf_op       (buf_op),
    .i_sample       (i_sample),
    .i_sample_valid (i_sample_valid),
    .o_rd_data      (rd_data),
    .o_busy_done    (busy_done)
  );

  host_watchdog u_watchdog (
    .i_clock    (i_clock),
    .i_arst_n   (i_arst_n),
    .i_kick     (cmd_valid),
    .o_wd_valid (wd_valid)
  );

  status_leds u_leds (
    .i_clock    (i_clock),
    .i_arst_n   (i_arst_n),
    .i_status   (status),
    .i_wd_valid (wd_valid),
    .o_led0     (o_led0),
    .o_led1     (o_led1)
  );

endmodule

/* hw/sample_buffer.sv */
`timescale 1ns/1ns

module sample_buffer (
  input  logic                          i_clock,
  input  logic                          i_arst_n,
  input  iagc_pkg::buf_ctrl_t           i_buf_op,
  input  logic [iagc_pkg::SAMPLE_W-1:0] i_sample,
  input  logic                          i_sample_valid,
  output logic [iagc_pkg::SAMPLE_W-1:0] o_rd_data,
  output logic                          o_busy_done
);
  import iagc_pkg::*;

  logic [SAMPLE_W-1:0] ref_mem [MEM_DEPTH];
  logic [SAMPLE_W-1:0] err_mem [MEM_DEPTH];

  logic [SAMPLE_W-1:0] dec_q;
  logic [SAMPLE_W-1:0] dec_last;
  logic [SAMPLE_W-1:0] dec_cnt;
  logic [MEM_AW-1:0]   clr_addr;
  logic [MEM_AW-1:0]   dump_addr;
  logic [MEM_AW-1:0]   cap_idx;
  logic [MEM_AW:0]     cap_addr;
  logic [MEM_AW:0]     cap_len;
  logic                clearing;
  logic                capturing;
  logic                dump_sel_q;
  logic                clr_we;
  logic                clr_last;
  logic                keep;
  logic                cap_last;

  assign clr_we   = i_buf_op.clear_start | clearing; // first write on the start cycle.
  assign clr_last = clr_we && (clr_addr == MEM_AW'(MEM_DEPTH - 1));

  assign dec_last = (dec_q == '0) ? '0 : dec_q - 1'b1;
  assign keep     = capturing && i_sample_valid && (dec_cnt == dec_last);
  assign cap_last = keep && (cap_addr == cap_len - 1'b1);
  assign cap_idx  = cap_addr[MEM_AW-1:0];

  assign o_busy_done = clr_last | cap_last;

  always_ff @(posedge i_clock) begin
    if (clr_we) begin
      ref_mem[clr_addr] <= '0;
    end else if (i_buf_op.set_mem) begin
      ref_mem[i_buf_op.addr] <= i_buf_op.data;
    end
  end

  always_ff @(posedge i_clock) begin
    if (clr_we) begin
      err_mem[clr_addr] <= '0;
    end else if (keep) begin
      err_mem[cap_idx] <= i_sample - ref_mem[cap_idx]; // wraps modulo 2^16.
    end
  end

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      clearing <= 1'b0;
      clr_addr <= '0;
    end else if (clr_we) begin
      clr_addr <= clr_addr + 1'b1;
      clearing <= !clr_last;
    end
  end

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      dec_q     <= '0;
      dec_cnt   <= '0;
      capturing <= 1'b0;
      cap_addr  <= '0;
      cap_len   <= '0;
    end else begin
      if (i_buf_op.set_dec) begin
        dec_q <= i_buf_op.value;
      end
      if (i_buf_op.capture_start) begin
        capturing <= 1'b1;
        cap_addr  <= '0;
        dec_cnt   <= '0;
        cap_len   <= i_buf_op.value[MEM_AW:0];
      end else if (keep) begin
        dec_cnt  <= '0;
        cap_addr <= cap_addr + 1'b1;
        if (cap_last) begin
          capturing <= 1'b0;
        end
      end else if (capturing && i_sample_valid) begin
        dec_cnt <= dec_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      dump_addr  <= '0;
      dump_sel_q <= 1'b0;
    end else if (i_buf_op.dump_start) begin
      dump_addr  <= '0;
      dump_sel_q <= i_buf_op.dump_sel;
    end else if (i_buf_op.dump_next) begin
      dump_addr <= dump_addr + 1'b1;
    end
  end

  assign o_rd_data = dump_sel_q ? err_mem[dump_addr] : ref_mem[dump_addr];

endmodule

/* hw/status_leds.sv */
`timescale 1ns/1ns

module status_leds (
  input  logic                   i_clock,
  input  logic                   i_arst_n,
  input  iagc_pkg::iagc_status_e i_status,
  input  logic                   i_wd_valid,
  output iagc_pkg::rgb_t         o_led0,
  output iagc_pkg::rgb_t         o_led1
);
  import iagc_pkg::*;

  localparam int PWM_W = $clog2(LED_PWM_TICKS + 1);

  logic [PWM_W-1:0] pwm_cnt;
  logic             pwm;

  // one tick every LED_PWM_TICKS+1 cycles.
  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pwm_cnt <= '0;
      pwm     <= 1'b0;
    end else if (pwm_cnt == PWM_W'(LED_PWM_TICKS)) begin
      pwm_cnt <= '0;
      pwm     <= 1'b1;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
      pwm     <= 1'b0;
    end
  end

  always_comb begin
    o_led0 = '0;
    case (i_status)
      INIT: begin
        o_led0.r = pwm;
      end
      IDLE: begin
        o_led0.g = pwm;
      end
      SAMPLE: begin
        o_led0.b = pwm;
      end
      DUMP_REF, DUMP_ERR: begin
        o_led0.r = pwm; // amber while dumping.
        o_led0.g = pwm;
      end
      default: begin
        o_led0 = '0;
      end
    endcase
  end

  always_comb begin
    o_led1   = '0;
    o_led1.g = i_wd_valid & pwm;
    o_led1.r = !i_wd_valid & pwm;
  end

endmodule

/* hw/wb_cmd_port.sv */
`timescale 1ns/1ns

module wb_cmd_port (
  input  logic                          i_clock,
  input  logic                          i_arst_n,
  input  iagc_pkg::wb_req_t             i_wb,
  output iagc_pkg::wb_rsp_t             o_wb,
  output logic                          o_cmd_valid,
  output iagc_pkg::iagc_cmd_u           o_cmd,
  output logic                          o_data_rd,
  input  iagc_pkg::iagc_status_e        i_status,
  input  logic                          i_reject,
  output logic                          o_status_rd,
  input  logic                          i_wd_valid,
  input  logic [iagc_pkg::SAMPLE_W-1:0] i_rd_data
);
  import iagc_pkg::*;

  logic        served;
  logic        ack_q;
  logic        start;
  logic        is_dump;
  logic [31:0] rd_mux;
  logic [31:0] rd_q;

  // first cycle of a request not yet acknowledged.
  assign start = i_wb.cyc && i_wb.stb && !served;

  assign o_cmd_valid = start && i_wb.we && (i_wb.adr == REG_CMD);
  assign o_cmd       = i_wb.dat;
  assign o_data_rd   = start && !i_wb.we && (i_wb.adr == REG_DATA);
  assign o_status_rd = start && !i_wb.we && (i_wb.adr == REG_STATUS);

  assign is_dump = (i_status == DUMP_REF) || (i_status == DUMP_ERR);

  always_comb begin
    case (i_wb.adr)
      REG_DATA: begin
        rd_mux = is_dump ? {{(32 - SAMPLE_W){1'b0}}, i_rd_data} : '0; // data only while dumping.
      end
      REG_STATUS: begin
        rd_mux = {26'b0, i_reject, i_wd_valid, i_status};
      end
      default: begin
        rd_mux = '0;
      end
    endcase
  end

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      served <= 1'b0;
      ack_q  <= 1'b0;
    end else begin
      ack_q <= start;
      if (start) begin
        served <= 1'b1;
      end else if (!(i_wb.cyc && i_wb.stb)) begin
        served <= 1'b0; // rearm once the master drops the strobe.
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (start && !i_wb.we) begin
      rd_q <= rd_mux;
    end
  end

  assign o_wb.ack = ack_q;
  assign o_wb.dat = rd_q;

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic o_clock,
  output logic o_arst_n
);

  initial begin
    o_clock = 1'b0;
    forever #(PERIOD_NS / 2) o_clock = ~o_clock;
  end

  initial begin
    o_arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clock);
    #(PERIOD_NS / 10);
    o_arst_n = 1'b1; // released just after an edge.
  end

endmodule

/* tests/tb_iagc.sv */
`timescale 1ns/1ns

module tb_iagc;
  import iagc_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int ACK_LIMIT   = 16;
  localparam int POLL_LIMIT  = 400;

  // rough length of each test in clock cycles.
  localparam int RESET_TEST_CYCLES    = 8 * MEM_DEPTH;
  localparam int ROUND_TRIP_CYCLES    = 400;
  localparam int DECIMATION_CYCLES    = 400;
  localparam int REJECT_CYCLES        = 400;
  localparam int LED_CYCLES           = 600;
  localparam int WATCHDOG_TEST_CYCLES = WD_TIMEOUT + 200;
  localparam int TEST_CYCLES = RESET_TEST_CYCLES + ROUND_TRIP_CYCLES + DECIMATION_CYCLES +
                               REJECT_CYCLES + LED_CYCLES + WATCHDOG_TEST_CYCLES;
  localparam int RUN_LIMIT_NS = TEST_CYCLES * 2 * CLK_PERIOD;

  localparam rgb_t LED_RED   = 3'b100;
  localparam rgb_t LED_GREEN = 3'b010;
  localparam rgb_t LED_BLUE  = 3'b001;

  logic                clock;
  logic                arst_n;
  wb_req_t             wb_req;
  wb_rsp_t             wb_rsp;
  logic [SAMPLE_W-1:0] sample;
  logic                sample_valid;
  rgb_t                led0;
  rgb_t                led1;

  logic [SAMPLE_W-1:0] ref_model [MEM_DEPTH];
  logic [SAMPLE_W-1:0] err_model [MEM_DEPTH];
  int                  cap_n_model = MEM_DEPTH;
  int                  dec_model   = 0;
  int                  seed        = 33;
  int                  errors      = 0;
  int                  checks      = 0;
  int                  tests_run   = 0;
  int                  tests_failed = 0;
  int                  test_err_start = 0;
  string               cur_test;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (8)
  ) u_clock_gen (
    .o_clock  (clock),
    .o_arst_n (arst_n)
  );

  iagc_top u_dut (
    .i_clock        (clock),
    .i_arst_n       (arst_n),
    .i_wb           (wb_req),
    .o_wb           (wb_rsp),
    .i_sample       (sample),
    .i_sample_valid (sample_valid),
    .o_led0         (led0),
    .o_led1         (led1)
  );

  function automatic logic [31:0] cmd_word(input logic [3:0] op, input logic [7:0] addr,
                                           input logic [15:0] value);
    cmd_word = {op, 4'h0, addr, value};
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("error in %s: %s", cur_test, msg);
  endtask

  task automatic check_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("mismatch in %s: %s expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test       = name;
    test_err_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors > test_err_start) begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, errors - test_err_start);
    end else begin
      $display("test %s passed", cur_test);
    end
  endtask

  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int waited;
    waited     = 0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    do begin
      @(posedge clock);
      #DRIVE_DELAY;
      waited++;
    end while (!wb_rsp.ack && (waited < ACK_LIMIT));
    assert (wb_rsp.ack) else report_error($sformatf("no acknowledge from register %0d", adr));
    rdat   = wb_rsp.dat;
    wb_req = '0;
    @(posedge clock); // one idle cycle so the slave rearms.
    #DRIVE_DELAY;
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
    wb_access(1'b0, adr, 32'h0, data);
  endtask

  task automatic wait_status(input iagc_status_e target, output logic [31:0] word);
    int tries;
    tries = 0;
    do begin
      wb_read(REG_STATUS, word);
      tries++;
    end while ((word[3:0] != target) && (tries < POLL_LIMIT));
    assert (word[3:0] == target) else
      report_error($sformatf("status never reached %s", target.name()));
  endtask

  task automatic poll_idle(output logic [31:0] word);
    wait_status(IDLE, word);
  endtask

  task automatic feed_samples(input int n);
    logic [31:0] rnd;
    int          kept;
    int          seen;
    int          d_eff;
    kept  = 0;
    seen  = 0;
    d_eff = (dec_model == 0) ? 1 : dec_model;
    while (kept < n) begin
      @(posedge clock);
      #DRIVE_DELAY;
      rnd          = $random(seed);
      sample_valid = rnd[0];
      sample       = rnd[31:16];
      if (sample_valid) begin
        if (seen == d_eff - 1) begin
          err_model[kept] = rnd[31:16] - ref_model[kept]; // every d-th valid sample is kept.
          kept++;
          seen = 0;
        end else begin
          seen++;
        end
      end
    end
    @(posedge clock);
    #DRIVE_DELAY;
    sample_valid = 1'b0;
  endtask

  task automatic start_capture(input int n);
    logic [31:0] word;
    wb_write(REG_CMD, cmd_word(OP_SAMPLE, 8'h00, 16'(n)));
    wait_status(SAMPLE, word);
    cap_n_model = n;
  endtask

  task automatic dump_check(input logic sel_err);
    logic [31:0]         word;
    logic [SAMPLE_W-1:0] exp;
    int                  k;
    wb_write(REG_CMD, cmd_word(sel_err ? OP_DUMP_ERR : OP_DUMP_REF, 8'h00, 16'h0000));
    wait_status(sel_err ? DUMP_ERR : DUMP_REF, word);
    for (k = 0; k < cap_n_model; k++) begin
      wb_read(REG_DATA, word);
      exp = sel_err ? err_model[k] : ref_model[k];
      check_equal($sformatf("%s word %0d", sel_err ? "error" : "reference", k),
                  {16'h0, exp}, word);
    end
    wb_read(REG_STATUS, word);
    check_equal("status after dump", 32'(IDLE), {28'h0, word[3:0]});
  endtask

  task automatic monitor_leds(input string phase, input int cycles, input rgb_t color0,
                              input rgb_t color1);
    int i;
    int since0;
    int pulses0;
    int pulses1;
    since0  = 0;
    pulses0 = 0;
    pulses1 = 0;
    for (i = 0; i < cycles; i++) begin
      @(posedge clock);
      #DRIVE_DELAY;
      since0++;
      if (led0 != 3'b000) begin
        check_equal($sformatf("led0 color in %s", phase), {29'h0, color0}, {29'h0, led0});
        if (pulses0 > 0) begin
          assert (since0 >= LED_PWM_TICKS + 1) else
            report_error($sformatf("led0 pulses only %0d cycles apart in %s", since0, phase));
        end
        pulses0++;
        since0 = 0;
      end
      if (led1 != 3'b000) begin
        check_equal($sformatf("led1 color in %s", phase), {29'h0, color1}, {29'h0, led1});
        pulses1++;
      end
    end
    assert (pulses0 > 0) else report_error($sformatf("led0 never pulsed in %s", phase));
    assert (pulses1 > 0) else report_error($sformatf("led1 never pulsed in %s", phase));
  endtask

  task automatic test_after_reset();
    logic [31:0] word;
    int          k;
    begin_test("after_reset");
    poll_idle(word);
    check_equal("status after init", 32'(IDLE), {28'h0, word[3:0]});
    for (k = 0; k < 4; k++) begin
      wb_write(REG_CMD, cmd_word(OP_SET_MEM, 8'(k * 67), 16'hc3a5 + 16'(k))); // wiped by the clear.
      poll_idle(word);
    end
    wb_write(REG_CMD, cmd_word(OP_CLEAN, 8'h00, 16'h0000));
    poll_idle(word);
    for (k = 0; k < MEM_DEPTH; k++) begin
      ref_model[k] = '0;
      err_model[k] = '0;
    end
    dump_check(1'b0);
    dump_check(1'b1);
    end_test();
  endtask

  task automatic test_ref_round_trip();
    logic [31:0] word;
    logic [31:0] rnd;
    int          n;
    int          a;
    int          k;
    begin_test("ref_round_trip");
    rnd = $random(seed);
    n   = 4 + int'(rnd[3:0]);
    for (k = 0; k < n + 4; k++) begin
      rnd = $random(seed);
      a   = (k < n) ? k : int'(rnd[7:0]) % n; // extra writes overwrite random words.
      wb_write(REG_CMD, cmd_word(OP_SET_MEM, 8'(a), rnd[31:16]));
      poll_idle(word);
      ref_model[a] = rnd[31:16];
    end
    start_capture(n);
    feed_samples(n);
    poll_idle(word);
    dump_check(1'b0);
    end_test();
  endtask

  task automatic test_decimation();
    logic [31:0] word;
    logic [31:0] rnd;
    int          n;
    int          d;
    begin_test("decimation");
    rnd = $random(seed);
    d   = 1 + int'(rnd[1:0]);
    n   = 4 + int'(rnd[4:2]);
    wb_write(REG_CMD, cmd_word(OP_SET_DEC, 8'h00, 16'(d)));
    poll_idle(word);
    dec_model = d;
    start_capture(n);
    feed_samples(n);
    poll_idle(word);
    dump_check(1'b1);
    end_test();
  endtask

  task automatic test_rejects();
    logic [31:0] word;
    logic [31:0] rnd;
    int          n;
    begin_test("rejects");
    rnd = $random(seed);
    wb_write(REG_CMD, cmd_word({1'b1, rnd[2:0]}, 8'h00, 16'h0000)); // opcodes 8 to 15.
    poll_idle(word);
    check_equal("reject flag after illegal opcode", 32'd1, {31'h0, word[5]});
    wb_read(REG_STATUS, word);
    check_equal("reject flag after status read", 32'd0, {31'h0, word[5]});
    n = 4 + int'(rnd[6:4]);
    start_capture(n);
    wb_write(REG_CMD, cmd_word(OP_SET_DEC, 8'h00, 16'd1));
    wb_read(REG_STATUS, word);
    check_equal("status during busy command", 32'(SAMPLE), {28'h0, word[3:0]});
    check_equal("reject flag after busy command", 32'd1, {31'h0, word[5]});
    wb_read(REG_STATUS, word);
    check_equal("reject flag after second read", 32'd0, {31'h0, word[5]});
    feed_samples(n);
    poll_idle(word);
    dump_check(1'b1);
    end_test();
  endtask

  task automatic test_leds();
    logic [31:0] word;
    logic [31:0] rnd;
    int          n;
    begin_test("leds");
    monitor_leds("idle", 200, LED_GREEN, LED_GREEN);
    rnd = $random(seed);
    n   = 2 + int'(rnd[2:0]);
    start_capture(n);
    monitor_leds("sample", 200, LED_BLUE, LED_GREEN);
    feed_samples(n);
    poll_idle(word);
    end_test();
  endtask

  task automatic test_watchdog();
    logic [31:0] word;
    begin_test("watchdog");
    repeat (WD_TIMEOUT + 10) @(posedge clock);
    #DRIVE_DELAY;
    wb_read(REG_STATUS, word);
    check_equal("watchdog flag after timeout", 32'd0, {31'h0, word[4]});
    monitor_leds("expired watchdog", 2 * (LED_PWM_TICKS + 1) + 2, LED_GREEN, LED_RED);
    wb_write(REG_CMD, cmd_word(OP_SET_DEC, 8'h00, 16'd1));
    poll_idle(word);
    dec_model = 1;
    check_equal("watchdog flag after command", 32'd1, {31'h0, word[4]});
    end_test();
  endtask

  initial begin
    #(RUN_LIMIT_NS);
    $display("error: run stopped by the timeout after %0d ns", RUN_LIMIT_NS);
    $display("Test failures found");
    $finish;
  end

  initial begin
    wb_req       = '0;
    sample       = '0;
    sample_valid = 1'b0;
    @(posedge arst_n);
    @(posedge clock);
    #DRIVE_DELAY;
    test_after_reset();
    test_ref_round_trip();
    test_decimation();
    test_rejects();
    test_leds();
    test_watchdog();
    $display("tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
